// File: list.f
logic/audio_player_pkg.sv
logic/player_ctrl_if.sv
logic/word_fetch_if.sv
logic/player_ctrl_regs.sv
logic/sample_rate_timer.sv
logic/flash_wb_reader.sv
logic/sample_sequencer.sv
logic/audio_player_top.sv
dv/tb_clock_gen.sv
dv/audio_player_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the audio player testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module audio_player_tb -Mdir obj_dir -f list.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vaudio_player_tb)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "Result: PASSED"; then
  exit 0
fi
exit 1

// File: dv/audio_player_tb.sv
`timescale 1ns/10ps

module audio_player_tb import audio_player_pkg::*; ();

  localparam int          TB_PERIOD      = 40;
  localparam int          TB_STEP        = 8;
  localparam int          TB_MIN_PERIOD  = 16;
  localparam int          TB_MAX_PERIOD  = 80;
  localparam int unsigned TB_WORDS       = 16;
  // About 150 samples at up to 80 cycles each plus margin
  localparam int          TIMEOUT_CYCLES = 40000;
  localparam logic [31:0] LFSR_SEED      = 32'h5178_0871;
  localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

  localparam int SPEED_UP   = 0;
  localparam int SPEED_DOWN = 1;
  localparam int SPEED_NORM = 2;

  logic        CLK_50M;
  logic        reset;
  logic        cmd_valid  = 1'b0;
  cmd_char_t   cmd_char   = '0;
  logic        speed_up   = 1'b0;
  logic        speed_down = 1'b0;
  logic        speed_norm = 1'b0;
  logic        wb_cyc;
  logic        wb_stb;
  flash_addr_t wb_adr;
  flash_word_t wb_dat_i   = '0;
  logic        wb_ack     = 1'b0;
  sample_t     sample;
  logic        sample_valid;
  period_t     sample_period;

  // Expected state, last emitted position and spacing bookkeeping
  logic                  exp_play       = 1'b0;
  logic                  exp_reverse    = 1'b0;
  flash_addr_t           exp_addr       = flash_addr_t'(TB_WORDS - 1);
  logic                  exp_half       = 1'b1;
  period_t               exp_period     = period_t'(TB_PERIOD);
  logic [FLASH_ADDR_W:0] step_pos;
  int                    cycle          = 0;
  int                    last_cycle     = 0;
  period_t               spacing_period = period_t'(TB_PERIOD);
  logic                  spacing_armed  = 1'b0;
  int                    samples_seen   = 0;

  // Flash slave state
  logic [31:0] lfsr       = LFSR_SEED;
  logic [1:0]  wait_left  = '0;
  logic        slave_busy = 1'b0;
  logic        drop_due   = 1'b0;

  tb_clock_gen #(
    .PERIOD_NS    (20),
    .RESET_CYCLES (4)
  ) clock_gen (
    .CLK_50M (CLK_50M),
    .reset   (reset)
  );

  audio_player_top #(
    .SAMPLE_PERIOD (period_t'(TB_PERIOD)),
    .SPEED_STEP    (period_t'(TB_STEP)),
    .MIN_PERIOD    (period_t'(TB_MIN_PERIOD)),
    .MAX_PERIOD    (period_t'(TB_MAX_PERIOD)),
    .NUM_WORDS     (TB_WORDS)
  ) uut (
    .CLK_50M       (CLK_50M),
    .reset         (reset),
    .cmd_valid     (cmd_valid),
    .cmd_char      (cmd_char),
    .speed_up      (speed_up),
    .speed_down    (speed_down),
    .speed_norm    (speed_norm),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_adr        (wb_adr),
    .wb_dat_i      (wb_dat_i),
    .wb_ack        (wb_ack),
    .sample        (sample),
    .sample_valid  (sample_valid),
    .sample_period (sample_period)
  );

  // ====================
  // Reference functions
  // ====================

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // Whole address and half index scrambled so the sign bit varies
  function automatic sample_t flash_half(input flash_addr_t a, input logic h);
    return sample_t'({a[14:0], h} ^ {8'h00, a[22:15]} ^ 16'hA5C3);
  endfunction

  function automatic flash_word_t flash_word(input flash_addr_t a);
    return {flash_half(a, 1'b1), flash_half(a, 1'b0)};
  endfunction

  // Samples form one ring of 2*TB_WORDS entries with the lower half first in each word
  function automatic logic [FLASH_ADDR_W:0] next_position(input flash_addr_t a,
                                                          input logic h, input logic rev);
    int idx;
    int last;
    idx  = 2 * int'(a) + int'(h);
    last = 2 * int'(TB_WORDS) - 1;
    if (rev)
      idx = (idx == 0) ? last : idx - 1;
    else
      idx = (idx == last) ? 0 : idx + 1;
    return {flash_addr_t'(idx / 2), idx[0]};
  endfunction

  function automatic period_t period_model(input period_t p, input int kind);
    int v;
    v = int'(p);
    case (kind)
      SPEED_UP:   v = (v - TB_STEP < TB_MIN_PERIOD) ? TB_MIN_PERIOD : v - TB_STEP;
      SPEED_DOWN: v = (v + TB_STEP > TB_MAX_PERIOD) ? TB_MAX_PERIOD : v + TB_STEP;
      default:    v = TB_PERIOD;
    endcase
    return period_t'(v);
  endfunction

  // ====================
  // Checks
  // ====================

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_sample(input sample_t expected, input sample_t actual);
    if (actual !== expected)
      stop_with_failure($sformatf(
        "MISMATCH time=%0t signal=sample expected=%0d actual=%0d",
        $time, expected, actual));
  endtask

  task automatic check_period(input period_t expected, input period_t actual);
    if (actual !== expected)
      stop_with_failure($sformatf(
        "MISMATCH time=%0t signal=sample_period expected=%0d actual=%0d",
        $time, expected, actual));
  endtask

  task automatic check_spacing(input period_t expected, input period_t actual);
    if (actual !== expected)
      stop_with_failure($sformatf(
        "MISMATCH time=%0t signal=sample_valid spacing expected=%0d actual=%0d",
        $time, expected, actual));
  endtask

  // ====================
  // Flash model and timeout
  // ====================

  always @(posedge CLK_50M)
  begin
    if (reset)
    begin
      wb_ack <= 1'b0;
      slave_busy = 1'b0;
      drop_due   = 1'b0;
    end
    else
    begin
      wb_ack <= 1'b0;
      // Cycle and strobe move together and drop right after the acknowledged cycle
      if (wb_cyc !== wb_stb)
        stop_with_failure("wb_cyc and wb_stb do not match on the flash bus");
      if (drop_due && wb_cyc)
        stop_with_failure("wb_cyc stayed high after the read was acknowledged");
      drop_due = wb_ack;
      if (wb_cyc && wb_stb && !wb_ack)
      begin
        if (!slave_busy)
        begin
          // Two LFSR bits give 0 to 3 wait states
          wait_left[0] = lfsr[0];
          lfsr = lfsr_next(lfsr);
          wait_left[1] = lfsr[0];
          lfsr = lfsr_next(lfsr);
          slave_busy = 1'b1;
          if (wb_adr >= TB_WORDS)
            stop_with_failure("Flash read outside the audio region");
        end
        if (wait_left == 2'd0)
        begin
          wb_ack   <= 1'b1;
          wb_dat_i <= flash_word(wb_adr);
          slave_busy = 1'b0;
        end
        else
          wait_left = wait_left - 2'd1;
      end
    end
  end

  always @(posedge CLK_50M)
  begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES)
      stop_with_failure($sformatf("Timeout after %0d cycles, the tests did not finish", cycle));
  end

  // ====================
  // Model update and compare
  // ====================

  always @(negedge CLK_50M)
  begin
    if (!reset)
    begin
      if (cmd_valid)
      begin
        case (cmd_char)
          CHAR_PLAY:
          begin
            if (!exp_play)
              spacing_armed = 1'b0;
            exp_play = 1'b1;
          end
          CHAR_PAUSE:    exp_play = 1'b0;
          CHAR_FORWARD:  exp_reverse = 1'b0;
          CHAR_BACKWARD: exp_reverse = 1'b1;
          CHAR_RESTART:
          begin
            // Position just before word 0 forward or just after word 15 reverse
            exp_addr = exp_reverse ? '0 : flash_addr_t'(TB_WORDS - 1);
            exp_half = ~exp_reverse;
          end
          default: ;
        endcase
      end
      if (speed_norm)
        exp_period = period_model(exp_period, SPEED_NORM);
      else if (speed_up)
        exp_period = period_model(exp_period, SPEED_UP);
      else if (speed_down)
        exp_period = period_model(exp_period, SPEED_DOWN);

      if (sample_valid)
      begin
        if (!exp_play)
          stop_with_failure("sample_valid pulsed while playback was paused");
        step_pos = next_position(exp_addr, exp_half, exp_reverse);
        exp_addr = step_pos[FLASH_ADDR_W:1];
        exp_half = step_pos[0];
        check_sample(flash_half(exp_addr, exp_half), sample);
        if (spacing_armed)
          check_spacing(spacing_period, period_t'(cycle - last_cycle));
        last_cycle     = cycle;
        spacing_period = exp_period;
        spacing_armed  = 1'b1;
        samples_seen   = samples_seen + 1;
      end
    end
  end

  // ====================
  // Stimulus
  // ====================

  task automatic send_cmd(input cmd_char_t c);
    @(posedge CLK_50M);
    cmd_valid <= 1'b1;
    cmd_char  <= c;
    @(posedge CLK_50M);
    cmd_valid <= 1'b0;
  endtask

  task automatic wait_sample();
    do
      @(negedge CLK_50M);
    while (sample_valid !== 1'b1);
  endtask

  task automatic wait_samples(input int n);
    repeat (n) wait_sample();
  endtask

  // Commands go out right after a sample and well clear of the next tick
  task automatic cmd_after_sample(input cmd_char_t c);
    wait_sample();
    send_cmd(c);
  endtask

  task automatic pulse_speed(input int kind);
    wait_sample();
    @(posedge CLK_50M);
    case (kind)
      SPEED_UP:   speed_up <= 1'b1;
      SPEED_DOWN: speed_down <= 1'b1;
      default:    speed_norm <= 1'b1;
    endcase
    @(posedge CLK_50M);
    speed_up   <= 1'b0;
    speed_down <= 1'b0;
    speed_norm <= 1'b0;
    @(negedge CLK_50M);
    check_period(exp_period, sample_period);
  endtask

  initial
  begin
    @(negedge reset);
    // No sample may appear before play
    repeat (6 * TB_PERIOD) @(posedge CLK_50M);
    @(negedge CLK_50M);
    check_period(period_t'(TB_PERIOD), sample_period);

    // Forward from word 0 with wrap
    send_cmd(CHAR_PLAY);
    wait_samples(40);

    // Reverse with wrap and then forward again
    cmd_after_sample(CHAR_BACKWARD);
    wait_samples(40);
    cmd_after_sample(CHAR_FORWARD);
    wait_samples(10);

    // Pause, resume and restart in both directions
    cmd_after_sample(CHAR_PAUSE);
    repeat (5 * TB_PERIOD) @(posedge CLK_50M);
    send_cmd(CHAR_PLAY);
    wait_samples(6);
    cmd_after_sample(CHAR_RESTART);
    wait_samples(5);
    cmd_after_sample(CHAR_BACKWARD);
    wait_samples(3);
    cmd_after_sample(CHAR_RESTART);
    wait_samples(5);
    cmd_after_sample(CHAR_FORWARD);
    wait_samples(3);

    // Speed steps and saturation
    repeat (4) pulse_speed(SPEED_UP);
    check_period(period_t'(TB_MIN_PERIOD), sample_period);
    wait_samples(4);
    pulse_speed(SPEED_NORM);
    repeat (6) pulse_speed(SPEED_DOWN);
    check_period(period_t'(TB_MAX_PERIOD), sample_period);
    wait_samples(3);
    pulse_speed(SPEED_NORM);
    pulse_speed(SPEED_UP);

    // Unknown characters including lower case
    cmd_after_sample(8'h58);
    cmd_after_sample(8'h62);
    cmd_after_sample(8'h00);
    wait_samples(8);
    @(negedge CLK_50M);
    check_period(exp_period, sample_period);
    pulse_speed(SPEED_NORM);
    wait_samples(4);

    if (samples_seen >= 100)
    begin
      $display("Result: PASSED");
      $finish;
    end
    else
      stop_with_failure($sformatf("Only %0d samples were played", samples_seen));
  end

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 4
) (
  output logic CLK_50M,
  output logic reset
);

  initial
  begin
    CLK_50M = 1'b0;
    forever #(PERIOD_NS / 2) CLK_50M = ~CLK_50M;
  end

  // Reset released on a rising edge
  initial
  begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK_50M);
    reset <= 1'b0;
  end

endmodule

// File: logic/audio_player_top.sv
`timescale 1ns/10ps

module audio_player_top import audio_player_pkg::*; #(
  parameter period_t     SAMPLE_PERIOD = DEFAULT_PERIOD,
  parameter period_t     SPEED_STEP    = DEFAULT_STEP,
  parameter period_t     MIN_PERIOD    = DEFAULT_MIN_PERIOD,
  parameter period_t     MAX_PERIOD    = DEFAULT_MAX_PERIOD,
  parameter int unsigned NUM_WORDS     = DEFAULT_NUM_WORDS
) (
  input  logic        CLK_50M,
  input  logic        reset,

  // Commands and speed buttons
  input  logic        cmd_valid,
  input  cmd_char_t   cmd_char,
  input  logic        speed_up,
  input  logic        speed_down,
  input  logic        speed_norm,

  // Wishbone read master to the flash
  output logic        wb_cyc,
  output logic        wb_stb,
  output flash_addr_t wb_adr,
  input  flash_word_t wb_dat_i,
  input  logic        wb_ack,

  // Audio out
  output sample_t     sample,
  output logic        sample_valid,
  output period_t     sample_period
);

  player_ctrl_if ctrl_bus ();
  word_fetch_if  fetch_bus ();

  logic tick;

  player_ctrl_regs #(
    .SAMPLE_PERIOD (SAMPLE_PERIOD),
    .SPEED_STEP    (SPEED_STEP),
    .MIN_PERIOD    (MIN_PERIOD),
    .MAX_PERIOD    (MAX_PERIOD)
  ) u_ctrl (
    .CLK_50M    (CLK_50M),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd_char   (cmd_char),
    .speed_up   (speed_up),
    .speed_down (speed_down),
    .speed_norm (speed_norm),
    .period_out (sample_period),
    .ctrl       (ctrl_bus.ctrl)
  );

  sample_rate_timer u_timer (
    .CLK_50M (CLK_50M),
    .reset   (reset),
    .ctrl    (ctrl_bus.timer),
    .tick    (tick)
  );

  sample_sequencer #(
    .NUM_WORDS (NUM_WORDS)
  ) u_seq (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .tick         (tick),
    .ctrl         (ctrl_bus.seq),
    .fetch        (fetch_bus.requester),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

  flash_wb_reader u_reader (
    .CLK_50M  (CLK_50M),
    .reset    (reset),
    .fetch    (fetch_bus.responder),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_adr   (wb_adr),
    .wb_dat_i (wb_dat_i),
    .wb_ack   (wb_ack)
  );

endmodule

// File: logic/sample_sequencer.sv
`timescale 1ns/10ps

module sample_sequencer import audio_player_pkg::*; #(
  parameter int unsigned NUM_WORDS = DEFAULT_NUM_WORDS
) (
  input  logic    CLK_50M,
  input  logic    reset,
  input  logic    tick,
  player_ctrl_if.seq ctrl,
  word_fetch_if.requester fetch,
  output sample_t sample,
  output logic    sample_valid
);

  localparam flash_addr_t LAST_ADDR = flash_addr_t'(NUM_WORDS - 1);

  function automatic flash_addr_t addr_step(input flash_addr_t a, input logic rev);
    if (rev)
      return (a == '0) ? LAST_ADDR : a - 1'b1;
    else
      return (a == LAST_ADDR) ? '0 : a + 1'b1;
  endfunction

  // Position of the last emitted sample and the word it came from
  flash_addr_t pos_addr;
  logic        pos_half;
  flash_word_t cur_word;
  logic        cur_ok;

  // Prefetched word, tagged with its address
  flash_word_t nxt_word;
  flash_addr_t nxt_addr;
  logic        nxt_ok;

  flash_addr_t req_addr;
  logic        req_q;
  logic        busy;
  logic        pending;
  sample_t     sample_q;
  logic        valid_q;

  flash_addr_t tgt_addr;
  logic        tgt_half;
  flash_word_t tgt_word;
  flash_addr_t nbr_addr;
  logic        in_cur;
  logic        in_fetch;
  logic        in_nxt;
  logic        have;
  logic        want_pre;
  logic        go;
  logic        issue;

  // ====================
  // Next sample lookup
  // ====================

  // Forward walks lower then upper, reverse walks upper then lower
  assign tgt_half = ~pos_half;
  assign tgt_addr = (pos_half != ctrl.reverse) ? addr_step(pos_addr, ctrl.reverse) : pos_addr;
  assign nbr_addr = addr_step(pos_addr, ctrl.reverse);

  assign in_cur   = cur_ok && (tgt_addr == pos_addr);
  assign in_fetch = fetch.done && (req_addr == tgt_addr);
  assign in_nxt   = nxt_ok && (nxt_addr == tgt_addr);
  assign have     = in_cur || in_fetch || in_nxt;

  // Fetch data bypasses the buffer so a held tick goes out right after done
  assign tgt_word = in_cur ? cur_word : (in_fetch ? fetch.data : nxt_word);

  assign go = ctrl.play && (tick || pending) && have && !ctrl.restart;

  // Neighbour word once the current word is being played
  assign want_pre = in_cur && !(nxt_ok && (nxt_addr == nbr_addr));
  assign issue    = !busy && !ctrl.restart && (!have || want_pre);

  // ====================
  // Control state
  // ====================

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      pos_addr <= LAST_ADDR;
      pos_half <= 1'b1;
      cur_ok   <= 1'b0;
      nxt_ok   <= 1'b0;
      busy     <= 1'b0;
      req_q    <= 1'b0;
      pending  <= 1'b0;
      valid_q  <= 1'b0;
    end
    else
    begin
      req_q   <= issue;
      valid_q <= go;

      if (issue)
        busy <= 1'b1;
      else if (fetch.done)
        busy <= 1'b0;

      if (fetch.done)
        nxt_ok <= 1'b1;

      // Only one tick is held
      if (!ctrl.play || ctrl.restart || go)
        pending <= 1'b0;
      else if (tick)
        pending <= 1'b1;

      // Park just before the start word so the next step lands on it
      if (ctrl.restart)
      begin
        cur_ok   <= 1'b0;
        pos_addr <= ctrl.reverse ? '0 : LAST_ADDR;
        pos_half <= ~ctrl.reverse;
      end
      else if (go)
      begin
        pos_addr <= tgt_addr;
        pos_half <= tgt_half;
        cur_ok   <= 1'b1;
      end
    end
  end

  // Payload registers
  always_ff @(posedge CLK_50M)
  begin
    if (go && !in_cur)
      cur_word <= tgt_word;
    if (fetch.done)
    begin
      nxt_word <= fetch.data;
      nxt_addr <= req_addr;
    end
    if (issue)
      req_addr <= have ? nbr_addr : tgt_addr;
    if (go)
      sample_q <= tgt_half ? tgt_word[31:16] : tgt_word[15:0];
  end

  assign fetch.req    = req_q;
  assign fetch.addr   = req_addr;
  assign sample       = sample_q;
  assign sample_valid = valid_q;

  // One request in flight, closed by the reader's done
  a_req_idle : assert property (@(posedge CLK_50M) disable iff (reset)
    fetch.req |-> !$past(busy));

  a_done_owned : assert property (@(posedge CLK_50M) disable iff (reset)
    fetch.done |-> busy);

endmodule

// File: logic/flash_wb_reader.sv
`timescale 1ns/10ps

module flash_wb_reader import audio_player_pkg::*; (
  input  logic        CLK_50M,
  input  logic        reset,
  word_fetch_if.responder fetch,
  output logic        wb_cyc,
  output logic        wb_stb,
  output flash_addr_t wb_adr,
  input  flash_word_t wb_dat_i,
  input  logic        wb_ack
);

  typedef enum logic {
    ST_IDLE,
    ST_BUSY
  } state_t;

  state_t      state;
  logic        stb_q;
  logic        done_q;
  flash_addr_t adr_q;
  flash_word_t data_q;

  // ====================
  // Bus FSM
  // ====================

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      state  <= ST_IDLE;
      stb_q  <= 1'b0;
      done_q <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (fetch.req)
          begin
            stb_q <= 1'b1;
            state <= ST_BUSY;
          end
        end
        ST_BUSY:
        begin
          // Single read that ends on the first ack
          if (wb_ack)
          begin
            stb_q  <= 1'b0;
            done_q <= 1'b1;
            state  <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Address and read data
  always_ff @(posedge CLK_50M)
  begin
    if ((state == ST_IDLE) && fetch.req)
      adr_q <= fetch.addr;
    if ((state == ST_BUSY) && wb_ack)
      data_q <= wb_dat_i;
  end

  assign wb_cyc     = (state == ST_BUSY);
  assign wb_stb     = stb_q;
  assign wb_adr     = adr_q;
  assign fetch.done = done_q;
  assign fetch.data = data_q;

  a_stb_in_cyc : assert property (@(posedge CLK_50M) disable iff (reset)
    wb_stb |-> wb_cyc);

endmodule

// File: logic/sample_rate_timer.sv
`timescale 1ns/10ps

module sample_rate_timer import audio_player_pkg::*; (
  input  logic CLK_50M,
  input  logic reset,
  player_ctrl_if.timer ctrl,
  output logic tick
);

  period_t count;
  logic    play_q;
  logic    tick_q;

  // Reload at every tick so a new period starts with the next interval
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      count  <= '0;
      play_q <= 1'b0;
      tick_q <= 1'b0;
    end
    else
    begin
      play_q <= ctrl.play;
      tick_q <= 1'b0;
      if (ctrl.play)
      begin
        if (!play_q)
        begin
          // Fresh count on resume
          count <= ctrl.period - 16'd1;
        end
        else if (count == '0)
        begin
          count  <= ctrl.period - 16'd1;
          tick_q <= 1'b1;
        end
        else
        begin
          count <= count - 16'd1;
        end
      end
    end
  end

  assign tick = tick_q;

endmodule

// File: logic/player_ctrl_regs.sv
`timescale 1ns/10ps

module player_ctrl_regs import audio_player_pkg::*; #(
  parameter period_t SAMPLE_PERIOD = DEFAULT_PERIOD,
  parameter period_t SPEED_STEP    = DEFAULT_STEP,
  parameter period_t MIN_PERIOD    = DEFAULT_MIN_PERIOD,
  parameter period_t MAX_PERIOD    = DEFAULT_MAX_PERIOD
) (
  input  logic       CLK_50M,
  input  logic       reset,
  input  logic       cmd_valid,
  input  cmd_char_t  cmd_char,
  input  logic       speed_up,
  input  logic       speed_down,
  input  logic       speed_norm,
  output period_t    period_out,
  player_ctrl_if.ctrl ctrl
);

  logic    play_q;
  logic    reverse_q;
  logic    restart_q;
  period_t period_q;

  // One extra bit to catch overflow and borrow
  logic [16:0] period_up;
  logic [16:0] period_dn;

  assign period_up = {1'b0, period_q} + {1'b0, SPEED_STEP};
  assign period_dn = {1'b0, period_q} - {1'b0, SPEED_STEP};

  // ====================
  // Command decode
  // ====================

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      play_q    <= 1'b0;
      reverse_q <= 1'b0;
      restart_q <= 1'b0;
    end
    else
    begin
      restart_q <= cmd_valid && (cmd_char == CHAR_RESTART);
      if (cmd_valid)
      begin
        case (cmd_char)
          CHAR_PLAY:     play_q    <= 1'b1;
          CHAR_PAUSE:    play_q    <= 1'b0;
          CHAR_FORWARD:  reverse_q <= 1'b0;
          CHAR_BACKWARD: reverse_q <= 1'b1;
          default:       ;
        endcase
      end
    end
  end

  // ====================
  // Speed register
  // ====================

  // Normal wins over up, up wins over down
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      period_q <= SAMPLE_PERIOD;
    end
    else if (speed_norm)
    begin
      period_q <= SAMPLE_PERIOD;
    end
    else if (speed_up)
    begin
      if (period_dn[16] || (period_dn[15:0] < MIN_PERIOD))
        period_q <= MIN_PERIOD;
      else
        period_q <= period_dn[15:0];
    end
    else if (speed_down)
    begin
      if (period_up > {1'b0, MAX_PERIOD})
        period_q <= MAX_PERIOD;
      else
        period_q <= period_up[15:0];
    end
  end

  assign ctrl.play    = play_q;
  assign ctrl.reverse = reverse_q;
  assign ctrl.restart = restart_q;
  assign ctrl.period  = period_q;
  assign period_out   = period_q;

  // Timer relies on a period that is never out of range
  a_period_bounds : assert property (@(posedge CLK_50M) disable iff (reset)
    (period_q >= MIN_PERIOD) && (period_q <= MAX_PERIOD));

endmodule

// File: logic/word_fetch_if.sv
`timescale 1ns/10ps

interface word_fetch_if import audio_player_pkg::*; ();

  // Request side, req is a single-cycle pulse
  logic        req;
  flash_addr_t addr;

  // Response side, done is a single-cycle pulse with data
  logic        done;
  flash_word_t data;

  modport requester (
    output req,
    output addr,
    input  done,
    input  data
  );

  modport responder (
    input  req,
    input  addr,
    output done,
    output data
  );

endinterface

// File: logic/player_ctrl_if.sv
`timescale 1ns/10ps

interface player_ctrl_if import audio_player_pkg::*; ();

  logic    play;
  logic    reverse;
  // One-cycle pulse
  logic    restart;
  period_t period;

  modport ctrl (
    output play,
    output reverse,
    output restart,
    output period
  );

  modport timer (
    input play,
    input period
  );

  modport seq (
    input play,
    input reverse,
    input restart
  );

endinterface

// File: logic/audio_player_pkg.sv
package audio_player_pkg;

  // ====================
  // Flash and sample types
  // ====================

  localparam int FLASH_ADDR_W = 23;

  typedef logic [FLASH_ADDR_W-1:0] flash_addr_t;
  typedef logic [31:0]             flash_word_t;
  typedef logic signed [15:0]      sample_t;

  // Sample period in CLK_50M cycles
  typedef logic [15:0] period_t;

  typedef logic [7:0] cmd_char_t;

  // ====================
  // Command characters
  // ====================

  // Upper-case ASCII letters
  localparam cmd_char_t CHAR_PLAY     = 8'h45;
  localparam cmd_char_t CHAR_PAUSE    = 8'h44;
  localparam cmd_char_t CHAR_FORWARD  = 8'h46;
  localparam cmd_char_t CHAR_BACKWARD = 8'h42;
  localparam cmd_char_t CHAR_RESTART  = 8'h52;

  // ====================
  // Defaults
  // ====================

  // 50 MHz / 2272 is roughly 22 kHz
  localparam period_t DEFAULT_PERIOD     = 16'd2272;
  localparam period_t DEFAULT_STEP       = 16'd16;
  localparam period_t DEFAULT_MIN_PERIOD = 16'd64;
  localparam period_t DEFAULT_MAX_PERIOD = 16'd8192;

  // Words in the audio region of the flash
  localparam logic [23:0] DEFAULT_NUM_WORDS = 24'h80000;

endpackage
